//--- design/csr_pkg.sv
package csr_pkg;

  // Data width of the core
  localparam int xlen = 32;

  // CSR addresses
  localparam logic [11:0] addr_sstatus = 12'h100;
  localparam logic [11:0] addr_sie     = 12'h104;
  localparam logic [11:0] addr_sepc    = 12'h141;
  localparam logic [11:0] addr_scause  = 12'h142;
  localparam logic [11:0] addr_sip     = 12'h144;
  localparam logic [11:0] addr_mstatus = 12'h300;
  localparam logic [11:0] addr_mie     = 12'h304;
  localparam logic [11:0] addr_mepc    = 12'h341;
  localparam logic [11:0] addr_mcause  = 12'h342;
  localparam logic [11:0] addr_mip     = 12'h344;

  // mstatus fields, MPP is two bits wide
  localparam int bit_sie  = 1;
  localparam int bit_mie  = 3;
  localparam int bit_spie = 5;
  localparam int bit_mpie = 7;
  localparam int bit_spp  = 8;
  localparam int bit_mpp  = 11;
  localparam int bit_mprv = 17;

  // Interrupt bits in mip and mie, same values as the cause codes
  localparam int irq_ssi = 1;
  localparam int irq_msi = 3;
  localparam int irq_sti = 5;
  localparam int irq_mti = 7;
  localparam int irq_sei = 9;
  localparam int irq_mei = 11;

  // Privilege modes
  localparam logic [1:0] priv_u = 2'b00;
  localparam logic [1:0] priv_s = 2'b01;
  localparam logic [1:0] priv_m = 2'b11;

  // Exception codes, ecall adds the current privilege
  localparam logic [xlen-2:0] exc_illegal    = 2;
  localparam logic [xlen-2:0] exc_ecall_base = 8;

  // Writable and visible fields
  localparam logic [xlen-1:0] sstatus_mask =
      (xlen'(1) << bit_sie) | (xlen'(1) << bit_spie) | (xlen'(1) << bit_spp);
  localparam logic [xlen-1:0] mstatus_mask =
      sstatus_mask | (xlen'(1) << bit_mie) | (xlen'(1) << bit_mpie) |
      (xlen'(3) << bit_mpp) | (xlen'(1) << bit_mprv);
  localparam logic [xlen-1:0] sint_mask =
      (xlen'(1) << irq_ssi) | (xlen'(1) << irq_sti) | (xlen'(1) << irq_sei);
  localparam logic [xlen-1:0] mint_mask =
      sint_mask | (xlen'(1) << irq_msi) | (xlen'(1) << irq_mti) | (xlen'(1) << irq_mei);
  // Pending bits that software may set
  localparam logic [xlen-1:0] mip_sw_mask = (xlen'(1) << irq_sti) | (xlen'(1) << irq_sei);

  // A CSR word, either plain or read as a trap cause
  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic            interrupt;
      logic [xlen-2:0] code;
    } cause;
  } csr_word_u;

endpackage

//--- design/machine_timer.sv
module machine_timer (
  input  logic        clock,
  input  logic        reset,
  input  logic        mtimecmp_wr,
  input  logic [63:0] mtimecmp_data,
  output logic [63:0] mtime,
  output logic        mtip
);

  logic [63:0] mtimecmp;

  // Free-running time base
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // Compare value, all ones keeps the timer quiet after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      mtimecmp <= '1;
    end else if (mtimecmp_wr) begin
      mtimecmp <= mtimecmp_data;
    end
  end

  // Pending level follows the compare directly
  assign mtip = (mtime >= mtimecmp);

endmodule

//--- design/interrupt_arbiter.sv
module interrupt_arbiter (
  input  logic [csr_pkg::xlen-1:0] mip_sw,
  input  logic [csr_pkg::xlen-1:0] mie_bits,
  input  logic [1:0]               priv,
  input  logic                     status_mie,
  input  logic                     status_sie,
  input  logic                     msip,
  input  logic                     ssip,
  input  logic                     external_interrupt,
  input  logic                     mtip,
  output logic                     irq_valid,
  output csr_pkg::csr_word_u       irq_cause,
  output logic [csr_pkg::xlen-1:0] mip_word
);

  import csr_pkg::*;

  logic            m_enable;
  logic            s_enable;
  logic [xlen-1:0] level_mask;
  logic [xlen-1:0] pending;

  // Full mip view, hardware levels plus the software bits
  always_comb begin
    mip_word          = mip_sw & mip_sw_mask;
    mip_word[irq_ssi] = ssip;
    mip_word[irq_msi] = msip;
    mip_word[irq_mti] = mtip;
    mip_word[irq_mei] = external_interrupt;
  end

  // M-level taken below M or with MIE, S-level in U or in S with SIE
  assign m_enable = (priv != priv_m) || status_mie;
  assign s_enable = (priv == priv_u) || ((priv == priv_s) && status_sie);

  assign level_mask = ((m_enable ? (mint_mask & ~sint_mask) : '0)) |
                      ((s_enable ? sint_mask : '0));
  assign pending    = mip_word & mie_bits & level_mask;

  // Fixed order MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    irq_cause.raw = '0;
    irq_valid     = |pending;
    if (pending[irq_mei]) begin
      irq_cause.cause.code = (xlen-1)'(irq_mei);
    end else if (pending[irq_msi]) begin
      irq_cause.cause.code = (xlen-1)'(irq_msi);
    end else if (pending[irq_mti]) begin
      irq_cause.cause.code = (xlen-1)'(irq_mti);
    end else if (pending[irq_sei]) begin
      irq_cause.cause.code = (xlen-1)'(irq_sei);
    end else if (pending[irq_ssi]) begin
      irq_cause.cause.code = (xlen-1)'(irq_ssi);
    end else if (pending[irq_sti]) begin
      irq_cause.cause.code = (xlen-1)'(irq_sti);
    end
    irq_cause.cause.interrupt = irq_valid;
  end

endmodule

//--- design/privilege_fsm.sv
module privilege_fsm (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     status_wr,
  input  logic                     sstatus_wr,
  input  logic [csr_pkg::xlen-1:0] wr_data,
  input  logic                     mret,
  input  logic                     sret,
  input  logic                     illegal_instruction,
  input  logic                     ecall,
  input  logic                     irq_valid,
  input  csr_pkg::csr_word_u       irq_cause,
  output logic [1:0]               priv,
  output logic                     status_mie,
  output logic                     status_sie,
  output logic [csr_pkg::xlen-1:0] status_word,
  output logic                     trap,
  output csr_pkg::csr_word_u       trap_cause
);

  import csr_pkg::*;

  logic       mpie;
  logic       spie;
  logic       spp;
  logic       mprv;
  logic [1:0] mpp;
  logic [1:0] priv_next;

  // Interrupts win over illegal instruction, then ecall
  assign trap = irq_valid || illegal_instruction || ecall;

  always_comb begin
    trap_cause.raw = '0;
    if (irq_valid) begin
      trap_cause = irq_cause;
    end else if (illegal_instruction) begin
      trap_cause.cause.code = exc_illegal;
    end else if (ecall) begin
      trap_cause.cause.code = exc_ecall_base + (xlen-1)'(priv);
    end
  end

  // Mode transitions, every trap lands in M
  always_comb begin
    priv_next = priv;
    if (trap) begin
      priv_next = priv_m;
    end else if (mret) begin
      priv_next = mpp;
    end else if (sret) begin
      priv_next = {1'b0, spp};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      priv <= priv_m;
    end else begin
      priv <= priv_next;
    end
  end

  // mstatus trap stack
  always_ff @(posedge clock) begin
    if (reset) begin
      status_mie <= 1'b0;
      status_sie <= 1'b0;
      mpie       <= 1'b0;
      spie       <= 1'b0;
      spp        <= 1'b0;
      mprv       <= 1'b0;
      mpp        <= priv_u;
    end else if (trap) begin
      status_mie <= 1'b0;
      mpie       <= status_mie;
      mpp        <= priv;
    end else if (mret) begin
      status_mie <= mpie;
      mpie       <= 1'b1;
      mpp        <= priv_m;
      // Leaving M drops modified privilege
      if (mpp != priv_m) begin
        mprv <= 1'b0;
      end
    end else if (sret) begin
      status_sie <= spie;
      spie       <= 1'b1;
      spp        <= 1'b1;
      mprv       <= 1'b0;
    end else if (status_wr) begin
      status_mie <= wr_data[bit_mie];
      mpie       <= wr_data[bit_mpie];
      mprv       <= wr_data[bit_mprv];
      status_sie <= wr_data[bit_sie];
      spie       <= wr_data[bit_spie];
      spp        <= wr_data[bit_spp];
      // Reserved encoding 2 keeps the old MPP
      if (wr_data[bit_mpp +: 2] != 2'b10) begin
        mpp <= wr_data[bit_mpp +: 2];
      end
    end else if (sstatus_wr) begin
      status_sie <= wr_data[bit_sie];
      spie       <= wr_data[bit_spie];
      spp        <= wr_data[bit_spp];
    end
  end

  always_comb begin
    status_word               = '0;
    status_word[bit_sie]      = status_sie;
    status_word[bit_mie]      = status_mie;
    status_word[bit_spie]     = spie;
    status_word[bit_mpie]     = mpie;
    status_word[bit_spp]      = spp;
    status_word[bit_mpp +: 2] = mpp;
    status_word[bit_mprv]     = mprv;
  end

endmodule

//--- design/csr_file.sv
module csr_file (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic [11:0]              addr,
  input  logic [csr_pkg::xlen-1:0] wr_data,
  input  logic [csr_pkg::xlen-1:0] pc,
  input  logic                     trap,
  input  csr_pkg::csr_word_u       trap_cause,
  input  logic [csr_pkg::xlen-1:0] status_word,
  input  logic [csr_pkg::xlen-1:0] mip_word,
  output logic [csr_pkg::xlen-1:0] rd_data,
  output logic [csr_pkg::xlen-1:0] mepc,
  output logic [csr_pkg::xlen-1:0] sepc,
  output logic                     status_wr,
  output logic                     sstatus_wr,
  output logic [csr_pkg::xlen-1:0] mie_bits,
  output logic [csr_pkg::xlen-1:0] mip_sw
);

  import csr_pkg::*;

  logic      wr_ok;
  logic      legal_cause;
  csr_word_u wr_word;
  csr_word_u mcause;
  csr_word_u scause;

  // A trap blocks software writes in its cycle
  assign wr_ok      = wr_en && !trap;
  assign status_wr  = wr_ok && (addr == addr_mstatus);
  assign sstatus_wr = wr_ok && (addr == addr_sstatus);

  // mie, S view only touches the S enables
  always_ff @(posedge clock) begin
    if (reset) begin
      mie_bits <= '0;
    end else if (wr_ok && (addr == addr_mie)) begin
      mie_bits <= wr_data & mint_mask;
    end else if (wr_ok && (addr == addr_sie)) begin
      mie_bits <= (mie_bits & ~sint_mask) | (wr_data & sint_mask);
    end
  end

  // Software STIP and SEIP
  always_ff @(posedge clock) begin
    if (reset) begin
      mip_sw <= '0;
    end else if (wr_ok && ((addr == addr_mip) || (addr == addr_sip))) begin
      mip_sw <= wr_data & mip_sw_mask;
    end
  end

  // Exception PCs are word aligned
  always_ff @(posedge clock) begin
    if (reset) begin
      mepc <= '0;
      sepc <= '0;
    end else begin
      if (trap) begin
        mepc <= pc;
      end else if (wr_ok && (addr == addr_mepc)) begin
        mepc <= {wr_data[xlen-1:2], 2'b00};
      end
      if (wr_ok && (addr == addr_sepc)) begin
        sepc <= {wr_data[xlen-1:2], 2'b00};
      end
    end
  end

  // mcause keeps only codes this core can raise
  assign wr_word.raw = wr_data;

  always_comb begin
    legal_cause = 1'b0;
    if (wr_word.cause.interrupt) begin
      case (wr_word.cause.code)
        (xlen-1)'(irq_ssi), (xlen-1)'(irq_msi), (xlen-1)'(irq_sti),
        (xlen-1)'(irq_mti), (xlen-1)'(irq_sei), (xlen-1)'(irq_mei): legal_cause = 1'b1;
        default: legal_cause = 1'b0;
      endcase
    end else begin
      case (wr_word.cause.code)
        exc_illegal,
        exc_ecall_base + (xlen-1)'(priv_u),
        exc_ecall_base + (xlen-1)'(priv_s),
        exc_ecall_base + (xlen-1)'(priv_m): legal_cause = 1'b1;
        default: legal_cause = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mcause.raw <= '0;
    end else if (trap) begin
      mcause <= trap_cause;
    end else if (wr_ok && (addr == addr_mcause) && legal_cause) begin
      mcause <= wr_word;
    end
  end

  // S view of the cause, M-level interrupts read as zero
  always_comb begin
    scause = mcause;
    if (mcause.cause.interrupt &&
        ((mcause.cause.code == (xlen-1)'(irq_msi)) ||
         (mcause.cause.code == (xlen-1)'(irq_mti)) ||
         (mcause.cause.code == (xlen-1)'(irq_mei)))) begin
      scause.raw = '0;
    end
  end

  always_comb begin
    case (addr)
      addr_sstatus: rd_data = status_word & sstatus_mask;
      addr_sie:     rd_data = mie_bits & sint_mask;
      addr_sepc:    rd_data = sepc;
      addr_scause:  rd_data = scause.raw;
      addr_sip:     rd_data = mip_word & sint_mask;
      addr_mstatus: rd_data = status_word & mstatus_mask;
      addr_mie:     rd_data = mie_bits;
      addr_mepc:    rd_data = mepc;
      addr_mcause:  rd_data = mcause.raw;
      addr_mip:     rd_data = mip_word & mint_mask;
      default:      rd_data = '0;
    endcase
  end

endmodule

//--- design/csr_unit.sv
module csr_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic [11:0]              addr,
  input  logic [csr_pkg::xlen-1:0] wr_data,
  input  logic [csr_pkg::xlen-1:0] pc,
  input  logic                     external_interrupt,
  input  logic                     msip,
  input  logic                     ssip,
  input  logic                     illegal_instruction,
  input  logic                     ecall,
  input  logic                     mret,
  input  logic                     sret,
  input  logic                     mtimecmp_wr,
  input  logic [63:0]              mtimecmp_data,
  output logic [csr_pkg::xlen-1:0] rd_data,
  output logic [csr_pkg::xlen-1:0] mepc,
  output logic [csr_pkg::xlen-1:0] sepc,
  output logic                     trap,
  output logic [1:0]               privilege_mode,
  output logic [63:0]              mtime
);

  import csr_pkg::*;

  logic            mtip;
  logic            status_wr;
  logic            sstatus_wr;
  logic [xlen-1:0] mie_bits;
  logic [xlen-1:0] mip_sw;
  logic [xlen-1:0] mip_word;
  logic [xlen-1:0] status_word;
  logic            status_mie;
  logic            status_sie;
  logic            irq_valid;
  csr_word_u       irq_cause;
  csr_word_u       trap_cause;

  machine_timer u_timer (
    .clock         (clock),
    .reset         (reset),
    .mtimecmp_wr   (mtimecmp_wr),
    .mtimecmp_data (mtimecmp_data),
    .mtime         (mtime),
    .mtip          (mtip)
  );

  interrupt_arbiter u_arbiter (
    .mip_sw             (mip_sw),
    .mie_bits           (mie_bits),
    .priv               (privilege_mode),
    .status_mie         (status_mie),
    .status_sie         (status_sie),
    .msip               (msip),
    .ssip               (ssip),
    .external_interrupt (external_interrupt),
    .mtip               (mtip),
    .irq_valid          (irq_valid),
    .irq_cause          (irq_cause),
    .mip_word           (mip_word)
  );

  privilege_fsm u_priv (
    .clock               (clock),
    .reset               (reset),
    .status_wr           (status_wr),
    .sstatus_wr          (sstatus_wr),
    .wr_data             (wr_data),
    .mret                (mret),
    .sret                (sret),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .irq_valid           (irq_valid),
    .irq_cause           (irq_cause),
    .priv                (privilege_mode),
    .status_mie          (status_mie),
    .status_sie          (status_sie),
    .status_word         (status_word),
    .trap                (trap),
    .trap_cause          (trap_cause)
  );

  csr_file u_csrs (
    .clock       (clock),
    .reset       (reset),
    .wr_en       (wr_en),
    .addr        (addr),
    .wr_data     (wr_data),
    .pc          (pc),
    .trap        (trap),
    .trap_cause  (trap_cause),
    .status_word (status_word),
    .mip_word    (mip_word),
    .rd_data     (rd_data),
    .mepc        (mepc),
    .sepc        (sepc),
    .status_wr   (status_wr),
    .sstatus_wr  (sstatus_wr),
    .mie_bits    (mie_bits),
    .mip_sw      (mip_sw)
  );

endmodule

//--- testbench/csr_unit_props.sv
module csr_unit_props (
  input logic       clock,
  input logic       reset,
  input logic [1:0] priv,
  input logic [1:0] mpp,
  input logic       trap
);

  timeunit 1ns;
  timeprecision 100ps;

  // Encoding 2 is reserved for both the mode and the stacked mode
  priv_legal: assert property (@(posedge clock) disable iff (reset) priv != 2'b10)
    else $error("privilege mode holds the reserved encoding");

  mpp_legal: assert property (@(posedge clock) disable iff (reset) mpp != 2'b10)
    else $error("MPP holds the reserved encoding");

  // Every trap lands in M
  trap_to_m: assert property (@(posedge clock) disable iff (reset) trap |=> priv == 2'b11)
    else $error("trap was not followed by M-mode");

endmodule

bind privilege_fsm csr_unit_props u_props (
  .clock (clock),
  .reset (reset),
  .priv  (priv),
  .mpp   (mpp),
  .trap  (trap)
);

//--- testbench/csr_unit_tb.sv
module csr_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import csr_pkg::*;

  logic        clock;
  logic        reset;
  logic        wr_en;
  logic [11:0] addr;
  logic [31:0] wr_data;
  logic [31:0] pc;
  logic        external_interrupt;
  logic        msip;
  logic        ssip;
  logic        illegal_instruction;
  logic        ecall;
  logic        mret;
  logic        sret;
  logic        mtimecmp_wr;
  logic [63:0] mtimecmp_data;
  logic [31:0] rd_data;
  logic [31:0] mepc;
  logic [31:0] sepc;
  logic        trap;
  logic [1:0]  privilege_mode;
  logic [63:0] mtime;

  // Shadow state of the reference model
  logic [1:0]  s_priv;
  logic [1:0]  s_mpp;
  logic        s_mie;
  logic        s_mpie;
  logic        s_sie;
  logic        s_spie;
  logic        s_spp;
  logic        s_mprv;
  logic [31:0] s_mie_bits;
  logic [31:0] s_mip_sw;
  logic [31:0] s_mepc;
  logic [31:0] s_sepc;
  csr_word_u   s_mcause;
  logic [63:0] s_time;
  logic [63:0] s_cmp;
  string       test_name;
  int          seed;

  csr_unit dut (.*);

  always #2 clock = ~clock;

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input csr_word_u exp, input csr_word_u act);
    if (act.raw !== exp.raw) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, exp.raw, act.raw);
      fail_run();
    end
  endtask

  task automatic check_priv(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_time(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
      fail_run();
    end
  endtask

  // Full pending word from hardware levels and software bits
  function automatic logic [31:0] pending_levels();
    logic [31:0] w;
    w            = s_mip_sw;
    w[irq_ssi]   = ssip;
    w[irq_msi]   = msip;
    w[irq_mti]   = (s_time >= s_cmp);
    w[irq_mei]   = external_interrupt;
    return w;
  endfunction

  // Highest-priority enabled interrupt, zero when none
  function automatic csr_word_u expect_irq();
    int          order[6] = '{11, 3, 7, 9, 1, 5};
    logic [31:0] pend;
    logic        men;
    logic        sen;
    csr_word_u   c;
    pend  = pending_levels() & s_mie_bits;
    men   = (s_priv != priv_m) || s_mie;
    sen   = (s_priv == priv_u) || ((s_priv == priv_s) && s_sie);
    c.raw = '0;
    for (int i = 0; i < 6; i++) begin
      if (c.raw == 0 && pend[order[i]] && ((i < 3) ? men : sen)) begin
        c.raw = 32'h8000_0000 | 32'(order[i]);
      end
    end
    return c;
  endfunction

  function automatic logic expect_trap();
    csr_word_u c;
    c = expect_irq();
    return c.cause.interrupt || illegal_instruction || ecall;
  endfunction

  function automatic logic legal_code(input csr_word_u w);
    if (w.cause.interrupt) begin
      return w.cause.code inside {1, 3, 5, 7, 9, 11};
    end
    return w.cause.code inside {2, 8, 9, 11};
  endfunction

  function automatic csr_word_u expect_read(input logic [11:0] a);
    logic [31:0] st;
    csr_word_u   r;
    st        = '0;
    st[1]     = s_sie;
    st[3]     = s_mie;
    st[5]     = s_spie;
    st[7]     = s_mpie;
    st[8]     = s_spp;
    st[12:11] = s_mpp;
    st[17]    = s_mprv;
    case (a)
      addr_sstatus: r.raw = st & 32'h0000_0122;
      addr_sie:     r.raw = s_mie_bits & 32'h0000_0222;
      addr_sepc:    r.raw = s_sepc;
      addr_scause: begin
        r = s_mcause;
        if (s_mcause.cause.interrupt && (s_mcause.cause.code inside {3, 7, 11})) begin
          r.raw = '0;
        end
      end
      addr_sip:     r.raw = pending_levels() & 32'h0000_0222;
      addr_mstatus: r.raw = st;
      addr_mie:     r.raw = s_mie_bits;
      addr_mepc:    r.raw = s_mepc;
      addr_mcause:  r = s_mcause;
      addr_mip:     r.raw = pending_levels() & 32'h0000_0aaa;
      default:      r.raw = '0;
    endcase
    return r;
  endfunction

  // Reference model, steps on every rising edge
  always @(posedge clock) begin : model
    csr_word_u c;
    if (reset) begin
      {s_mie, s_mpie, s_sie, s_spie, s_spp, s_mprv} = '0;
      s_priv = priv_m;
      s_mpp = priv_u;
      {s_mie_bits, s_mip_sw, s_mepc, s_sepc} = '0;
      s_mcause.raw = '0;
      s_time = '0;
      s_cmp = '1;
    end else begin
      c = expect_irq();
      if (c.cause.interrupt || illegal_instruction || ecall) begin
        if (!c.cause.interrupt) begin
          c.raw = illegal_instruction ? 32'd2 : 32'd8 + 32'(s_priv);
        end
        s_mepc = pc;
        s_mcause = c;
        s_mpie = s_mie;
        s_mie = 1'b0;
        s_mpp = s_priv;
        s_priv = priv_m;
      end else begin
        if (mret) begin
          s_priv = s_mpp;
          s_mie = s_mpie;
          s_mpie = 1'b1;
          if (s_mpp != priv_m) s_mprv = 1'b0;
          s_mpp = priv_m;
        end else if (sret) begin
          s_priv = {1'b0, s_spp};
          s_sie = s_spie;
          s_spie = 1'b1;
          s_spp = 1'b1;
          s_mprv = 1'b0;
        end else if (wr_en && addr == addr_mstatus) begin
          {s_mprv, s_spp, s_mpie, s_spie, s_mie, s_sie} =
              {wr_data[17], wr_data[8], wr_data[7], wr_data[5], wr_data[3], wr_data[1]};
          if (wr_data[12:11] != 2'b10) s_mpp = wr_data[12:11];
        end else if (wr_en && addr == addr_sstatus) begin
          {s_spp, s_spie, s_sie} = {wr_data[8], wr_data[5], wr_data[1]};
        end
        if (wr_en) begin
          case (addr)
            addr_mie:  s_mie_bits = wr_data & 32'h0000_0aaa;
            addr_sie:  s_mie_bits = (s_mie_bits & ~32'h222) | (wr_data & 32'h222);
            addr_mip, addr_sip: s_mip_sw = wr_data & 32'h0000_0220;
            addr_mepc: s_mepc = {wr_data[31:2], 2'b00};
            addr_sepc: s_sepc = {wr_data[31:2], 2'b00};
            addr_mcause: begin
              if (legal_code(wr_data)) s_mcause.raw = wr_data;
            end
            default: ;
          endcase
        end
      end
      if (mtimecmp_wr) s_cmp = mtimecmp_data;
      s_time = s_time + 64'd1;
    end
  end

  // Compares the DUT with the model every cycle
  always @(negedge clock) begin
    #0.5;
    if (!reset) begin
      check_word("rd_data", expect_read(addr), rd_data);
      check_word("mepc", s_mepc, mepc);
      check_word("sepc", s_sepc, sepc);
      check_priv("privilege_mode", s_priv, privilege_mode);
      check_flag("trap", expect_trap(), trap);
      check_time("mtime", s_time, mtime);
    end
  end

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    @(negedge clock);
    wr_en = 1'b1;
    addr = a;
    wr_data = d;
    @(negedge clock);
    wr_en = 1'b0;
  endtask

  task automatic read_check(input logic [11:0] a, input string name, input logic [31:0] exp);
    @(negedge clock);
    addr = a;
    #1;
    check_word(name, exp, rd_data);
  endtask

  // 0 mret, 1 sret, 2 ecall, 3 illegal instruction
  task automatic strobe(input int kind);
    @(negedge clock);
    case (kind)
      0: mret = 1'b1;
      1: sret = 1'b1;
      2: ecall = 1'b1;
      default: illegal_instruction = 1'b1;
    endcase
    @(negedge clock);
    {mret, sret, ecall, illegal_instruction} = '0;
  endtask

  task automatic wait_trap();
    int n;
    n = 0;
    while (trap !== 1'b1) begin
      if (n == 200) begin
        $display("Timed out waiting for trap in %s", test_name);
        fail_run();
      end
      @(negedge clock);
      #0.5;
      n++;
    end
  endtask

  initial begin
    csr_word_u   exp;
    logic [31:0] r;
    clock = 1'b0;
    reset = 1'b1;
    seed = 60;
    {wr_en, external_interrupt, msip, ssip, illegal_instruction} = '0;
    {ecall, mret, sret, mtimecmp_wr} = '0;
    addr = '0;
    wr_data = '0;
    pc = '0;
    mtimecmp_data = '0;
    test_name = "reset";
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    read_check(addr_sstatus, "sstatus", 0);
    read_check(addr_sie, "sie", 0);
    read_check(addr_sepc, "sepc", 0);
    read_check(addr_scause, "scause", 0);
    read_check(addr_sip, "sip", 0);
    read_check(addr_mstatus, "mstatus", 0);
    read_check(addr_mie, "mie", 0);
    read_check(addr_mepc, "mepc", 0);
    read_check(addr_mcause, "mcause", 0);
    read_check(addr_mip, "mip", 0);
    check_priv("mode", priv_m, privilege_mode);
    check_flag("trap", 1'b0, trap);

    test_name = "warl";
    csr_write(addr_mepc, 32'h1234_5677);
    read_check(addr_mepc, "mepc align", 32'h1234_5674);
    csr_write(addr_sepc, 32'h89ab_cdef);
    read_check(addr_sepc, "sepc align", 32'h89ab_cdec);
    csr_write(addr_mstatus, 32'h0002_19aa);
    read_check(addr_mstatus, "mstatus fields", 32'h0002_19aa);
    read_check(addr_sstatus, "sstatus view", 32'h0000_0122);
    csr_write(addr_mstatus, 32'h0000_1000);
    read_check(addr_mstatus, "mpp reserved", 32'h0000_1800);
    csr_write(addr_mstatus, 0);
    csr_write(addr_mie, 32'hffff_ffff);
    read_check(addr_sie, "sie view", 32'h0000_0222);
    csr_write(addr_mip, 32'hffff_ffff);
    @(negedge clock);
    msip = 1'b1;
    ssip = 1'b1;
    read_check(addr_sip, "sip view", 32'h0000_0222);
    @(negedge clock);
    msip = 1'b0;
    ssip = 1'b0;
    csr_write(addr_mip, 0);
    csr_write(addr_mie, 0);
    csr_write(addr_mcause, 32'h0000_0005);
    read_check(addr_mcause, "mcause illegal", 0);
    csr_write(addr_mcause, 32'h8000_0004);
    read_check(addr_mcause, "mcause illegal irq", 0);
    csr_write(addr_mcause, 32'h8000_0009);
    read_check(addr_mcause, "mcause legal", 32'h8000_0009);

    test_name = "ecall";
    csr_write(addr_mstatus, 0);
    strobe(0);
    check_priv("mode after mret", priv_u, privilege_mode);
    pc = 32'h0000_4a10;
    strobe(2);
    read_check(addr_mcause, "ecall cause", 32'd8);
    read_check(addr_mepc, "ecall mepc", 32'h0000_4a10);
    read_check(addr_mstatus, "ecall stack", 0);
    check_priv("mode after ecall", priv_m, privilege_mode);
    csr_write(addr_mstatus, 0);
    strobe(0);
    strobe(3);
    read_check(addr_mcause, "illegal cause", 32'd2);

    test_name = "timer";
    csr_write(addr_mie, 32'h0000_0080);
    csr_write(addr_mstatus, 32'h0000_0008);
    @(negedge clock);
    mtimecmp_wr = 1'b1;
    mtimecmp_data = s_time + 64'd20;
    @(negedge clock);
    mtimecmp_wr = 1'b0;
    wait_trap();
    read_check(addr_mcause, "timer cause", 32'h8000_0007);
    @(negedge clock);
    mtimecmp_wr = 1'b1;
    mtimecmp_data = s_time + 64'd100000;
    @(negedge clock);
    mtimecmp_wr = 1'b0;
    read_check(addr_mip, "mtip cleared", 0);

    test_name = "priority";
    for (int i = 0; i < 40; i++) begin
      csr_write(addr_mie, $random(seed) & 32'h0000_0aaa);
      csr_write(addr_mip, $random(seed) & 32'h0000_0220);
      csr_write(addr_mstatus, 0);
      r = $random(seed);
      @(negedge clock);
      mret = 1'b1;
      {external_interrupt, msip, ssip} = r[2:0];
      @(negedge clock);
      mret = 1'b0;
      #0.5;
      exp = expect_irq();
      if (exp.cause.interrupt) begin
        check_flag("irq trap", 1'b1, trap);
        @(negedge clock);
      end else begin
        @(negedge clock);
        ecall = 1'b1;
        @(negedge clock);
        ecall = 1'b0;
        exp.raw = 32'd8;
      end
      {external_interrupt, msip, ssip} = '0;
      addr = addr_mcause;
      #1;
      check_word("chosen cause", exp, rd_data);
    end
    csr_write(addr_mie, 0);
    csr_write(addr_mip, 0);

    test_name = "sret";
    csr_write(addr_mstatus, 32'h0000_0800);
    strobe(0);
    check_priv("mode after mret", priv_s, privilege_mode);
    csr_write(addr_sstatus, 32'h0000_0020);
    strobe(1);
    check_priv("mode after sret", priv_u, privilege_mode);
    @(negedge clock);
    addr = addr_sstatus;
    #1;
    check_word("sie and spie", 32'h0000_0022, rd_data & 32'h0000_0022);
    strobe(2);
    check_priv("mode after ecall", priv_m, privilege_mode);

    @(negedge clock);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
design/csr_pkg.sv
design/machine_timer.sv
design/interrupt_arbiter.sv
design/privilege_fsm.sv
design/csr_file.sv
design/csr_unit.sv
testbench/csr_unit_props.sv
testbench/csr_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= csr_unit_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
